// File: src/pixfx_pkg.sv
// ====================
// Shared widths, types and structs of the pixfx colour engine
// Channels are widened to 6 bits inside the lanes, RGB565 outside
// Addresses count 16-bit words and pass through unchanged
// ====================

package pixfx_pkg;

	// ====================
	// Widths and counts
	// ====================
	localparam int CHAN_W      = 6;  // One widened colour channel
	localparam int FRAC_W      = 6;  // Bilinear fractional weight
	localparam int FRAC_ONE    = 64; // Weight that stands for unity
	localparam int DADR_W      = 24; // Destination address, 16-bit words
	localparam int LANE_COUNT  = 3;  // Red, green, blue
	localparam int LANE_STAGES = 3;  // Blend, decay, alpha mix

	// ====================
	// Plain vector types
	// ====================
	typedef logic [15:0]         rgb565_t;
	typedef logic [CHAN_W-1:0]   chan_t;
	typedef logic [FRAC_W-1:0]   frac_t;
	typedef logic [5:0]          level_t;   // Brightness or opacity, 0 to 63
	typedef logic [DADR_W-1:0]   dadr_t;

	// Input pixel with its four neighbouring texels
	typedef struct packed {
		rgb565_t colora;  // Top left
		rgb565_t colorb;  // Top right
		rgb565_t colorc;  // Bottom left
		rgb565_t colord;  // Bottom right
		rgb565_t dcolor;  // Colour already in the frame buffer
		frac_t   x_frac;
		frac_t   y_frac;
		dadr_t   dadr;
	} pix_in_t;

	typedef struct packed {
		dadr_t   dadr;
		rgb565_t color;
	} pix_out_t;

	// Static levels, only changed while the engine is idle
	typedef struct packed {
		level_t  brightness;
		logic    chroma_key_en;
		rgb565_t chroma_key;
		logic    alpha_en;
		level_t  alpha;   // 63 is fully opaque
	} cfg_t;

	// Operands of one channel lane
	typedef struct packed {
		chan_t a;
		chan_t b;
		chan_t c;
		chan_t d;
		chan_t dst;
		frac_t x_frac;
		frac_t y_frac;
	} lane_in_t;

	typedef struct packed {
		chan_t blended;     // Bilinear result, used for the chroma key
		chan_t final_chan;  // After decay and alpha mix
	} lane_out_t;

endpackage

// File: src/pixfx_unpack.sv
// ====================
// Feeder stage, registers the pixel and splits it into channel operands
// Loads only on advance with a strobe, validity is tracked by the drain
// ====================

`timescale 1ns/1ps

module pixfx_unpack (
	input  logic                                          sys_clk_i,
	input  logic                                          sys_rst_i,
	input  logic                                          advance_i,
	input  logic                                          pix_stb_i,
	input  pixfx_pkg::pix_in_t                            pix_i,
	output pixfx_pkg::lane_in_t [pixfx_pkg::LANE_COUNT-1:0] lane_ops_o,
	output pixfx_pkg::dadr_t                              dadr_o
);

	pixfx_pkg::pix_in_t pix_q;

	// Widen one channel of an RGB565 colour to 6 bits
	function automatic pixfx_pkg::chan_t widen(
		input pixfx_pkg::rgb565_t c,
		input int                 lane
	);
		pixfx_pkg::chan_t ch;
		case (lane)
			0:       ch = {c[15:11], 1'b0};  // Red gains a zero LSB
			1:       ch = c[10:5];           // Green already 6 bits
			default: ch = {c[4:0], 1'b0};    // Blue gains a zero LSB
		endcase
		return ch;
	endfunction

	// ====================
	// Input register
	// ====================
	always_ff @(posedge sys_clk_i) begin
		if (sys_rst_i) begin
			pix_q <= '0;
		end else if (advance_i && pix_stb_i) begin
			pix_q <= pix_i;
		end
	end

	// ====================
	// Channel split
	// ====================
	always_comb begin
		for (int i = 0; i < pixfx_pkg::LANE_COUNT; i++) begin
			lane_ops_o[i].a      = widen(pix_q.colora, i);
			lane_ops_o[i].b      = widen(pix_q.colorb, i);
			lane_ops_o[i].c      = widen(pix_q.colorc, i);
			lane_ops_o[i].d      = widen(pix_q.colord, i);
			lane_ops_o[i].dst    = widen(pix_q.dcolor, i);
			// Same weights for every channel
			lane_ops_o[i].x_frac = pix_q.x_frac;
			lane_ops_o[i].y_frac = pix_q.y_frac;
		end
	end

	assign dadr_o = pix_q.dadr;  // Address rides the drain delay line

endmodule

// File: src/pixfx_lane.sv
// ====================
// One colour channel, three stages: bilinear blend, decay, alpha mix
// All stages move together on advance_i, results truncate toward zero
// ====================

`timescale 1ns/1ps

module pixfx_lane (
	input  logic                 sys_clk_i,
	input  logic                 sys_rst_i,
	input  logic                 advance_i,
	input  pixfx_pkg::cfg_t      cfg_i,
	input  pixfx_pkg::lane_in_t  ops_i,
	output pixfx_pkg::lane_out_t res_o
);

	// Blend weights, 0 to 64
	logic [pixfx_pkg::FRAC_W:0] wx0;
	logic [pixfx_pkg::FRAC_W:0] wx1;
	logic [pixfx_pkg::FRAC_W:0] wy0;
	logic [pixfx_pkg::FRAC_W:0] wy1;

	// Weighted sums, weights add up to one so nothing overflows
	logic [pixfx_pkg::CHAN_W+2*pixfx_pkg::FRAC_W-1:0] blend_sum;
	logic [pixfx_pkg::CHAN_W+pixfx_pkg::FRAC_W-1:0]   decay_prod;
	logic [pixfx_pkg::CHAN_W+pixfx_pkg::FRAC_W-1:0]   mix_sum;

	logic [6:0]       bright_p1;
	logic [6:0]       alpha_p1;
	pixfx_pkg::level_t alpha_inv;
	pixfx_pkg::chan_t  mix_chan;

	// Stage registers
	pixfx_pkg::chan_t s1_blend;
	pixfx_pkg::chan_t s1_dst;
	pixfx_pkg::chan_t s2_blend;
	pixfx_pkg::chan_t s2_decay;
	pixfx_pkg::chan_t s2_dst;
	pixfx_pkg::chan_t s3_blend;
	pixfx_pkg::chan_t s3_final;

	// ====================
	// Stage 1 blend
	// ====================
	assign wx1 = {1'b0, ops_i.x_frac};
	assign wy1 = {1'b0, ops_i.y_frac};
	assign wx0 = (pixfx_pkg::FRAC_W+1)'(pixfx_pkg::FRAC_ONE) - wx1;
	assign wy0 = (pixfx_pkg::FRAC_W+1)'(pixfx_pkg::FRAC_ONE) - wy1;

	assign blend_sum = ops_i.a * wx0 * wy0
		+ ops_i.b * wx1 * wy0
		+ ops_i.c * wx0 * wy1
		+ ops_i.d * wx1 * wy1;

	// ====================
	// Stage 2 decay
	// ====================
	assign bright_p1  = {1'b0, cfg_i.brightness} + 7'd1;
	assign decay_prod = s1_blend * bright_p1;

	// ====================
	// Stage 3 alpha mix
	// ====================
	assign alpha_p1  = {1'b0, cfg_i.alpha} + 7'd1;
	assign alpha_inv = 6'd63 - cfg_i.alpha;
	assign mix_sum   = s2_decay * alpha_p1 + s2_dst * alpha_inv;
	assign mix_chan  = cfg_i.alpha_en ? mix_sum[11:6] : s2_decay;

	always_ff @(posedge sys_clk_i) begin
		if (sys_rst_i) begin
			s1_blend <= '0;
			s1_dst   <= '0;
			s2_blend <= '0;
			s2_decay <= '0;
			s2_dst   <= '0;
			s3_blend <= '0;
			s3_final <= '0;
		end else if (advance_i) begin
			s1_blend <= blend_sum[17:12];  // Divide by 4096
			s1_dst   <= ops_i.dst;
			s2_blend <= s1_blend;
			s2_decay <= decay_prod[11:6];  // Divide by 64
			s2_dst   <= s1_dst;
			s3_blend <= s2_blend;
			s3_final <= mix_chan;
		end
	end

	assign res_o.blended    = s3_blend;
	assign res_o.final_chan = s3_final;

endmodule

// File: src/pixfx_pack.sv
// ====================
// Drain stage, owns flow control, chroma key and the output register
// A keyed pixel never reaches the output register
// ====================

`timescale 1ns/1ps

module pixfx_pack (
	input  logic                                           sys_clk_i,
	input  logic                                           sys_rst_i,
	input  pixfx_pkg::cfg_t                                cfg_i,
	input  logic                                           pix_stb_i,
	input  pixfx_pkg::dadr_t                               dadr_i,
	input  pixfx_pkg::lane_out_t [pixfx_pkg::LANE_COUNT-1:0] lane_res_i,
	input  logic                                           pix_ack_i,
	output logic                                           advance_o,
	output logic                                           pix_ack_o,
	output logic                                           pix_stb_o,
	output pixfx_pkg::pix_out_t                            pix_o,
	output logic                                           busy_o
);

	logic                              ready_q;  // Opens the input one cycle after reset
	logic [pixfx_pkg::LANE_STAGES:0]   vld_q;    // Bit 0 feeder, top bit last lane stage
	pixfx_pkg::dadr_t                  adr_q [pixfx_pkg::LANE_STAGES];
	logic                              out_vld_q;
	pixfx_pkg::pix_out_t               out_q;
	pixfx_pkg::rgb565_t                blend_565;
	pixfx_pkg::rgb565_t                final_565;
	logic                              keyed;
	logic                              advance;

	// Back to 5-6-5, red and blue drop their LSB
	function automatic pixfx_pkg::rgb565_t repack(
		input pixfx_pkg::chan_t r,
		input pixfx_pkg::chan_t g,
		input pixfx_pkg::chan_t b
	);
		return {r[5:1], g, b[5:1]};
	endfunction

	assign blend_565 = repack(lane_res_i[0].blended, lane_res_i[1].blended,
		lane_res_i[2].blended);
	assign final_565 = repack(lane_res_i[0].final_chan, lane_res_i[1].final_chan,
		lane_res_i[2].final_chan);
	assign keyed = cfg_i.chroma_key_en && (blend_565 == cfg_i.chroma_key);

	// ====================
	// Flow control
	// ====================
	assign advance   = ready_q & (~out_vld_q | pix_ack_i);  // Whole pipe moves or freezes
	assign advance_o = advance;
	assign pix_ack_o = advance;
	assign pix_stb_o = out_vld_q;
	assign pix_o     = out_q;
	assign busy_o    = (|vld_q) | out_vld_q;

	always_ff @(posedge sys_clk_i) begin
		if (sys_rst_i) begin
			ready_q   <= 1'b0;
			vld_q     <= '0;
			out_vld_q <= 1'b0;
		end else begin
			ready_q <= 1'b1;
			if (advance) begin
				vld_q     <= {vld_q[pixfx_pkg::LANE_STAGES-1:0], pix_stb_i};
				out_vld_q <= vld_q[pixfx_pkg::LANE_STAGES] & ~keyed;
			end
		end
	end

	// Address delay line and output payload
	always_ff @(posedge sys_clk_i) begin
		if (advance) begin
			adr_q[0] <= dadr_i;
			for (int i = 1; i < pixfx_pkg::LANE_STAGES; i++) begin
				adr_q[i] <= adr_q[i-1];
			end
			if (vld_q[pixfx_pkg::LANE_STAGES] && !keyed) begin
				out_q.dadr  <= adr_q[pixfx_pkg::LANE_STAGES-1];
				out_q.color <= final_565;
			end
		end
	end

endmodule

// File: src/pixfx_top.sv
// ====================
// pixfx streaming colour engine, stb/ack in and out
// Five register stages, latency five accepted cycles without stalls
// cfg_i may only change while busy_o is low
// ====================

`timescale 1ns/1ps

module pixfx_top (
	input  logic                 sys_clk_i,
	input  logic                 sys_rst_i,
	input  pixfx_pkg::cfg_t      cfg_i,

	// Pixel input
	input  logic                 pix_stb_i,
	input  pixfx_pkg::pix_in_t   pix_i,
	output logic                 pix_ack_o,

	// Pixel output
	output logic                 pix_stb_o,
	output pixfx_pkg::pix_out_t  pix_o,
	input  logic                 pix_ack_i,

	output logic                 busy_o
);

	logic                                                 advance;   // Shared stage enable
	pixfx_pkg::lane_in_t  [pixfx_pkg::LANE_COUNT-1:0]     lane_ops;
	pixfx_pkg::lane_out_t [pixfx_pkg::LANE_COUNT-1:0]     lane_res;
	pixfx_pkg::dadr_t                                     feed_dadr;

	pixfx_unpack i_unpack (
		.sys_clk_i  (sys_clk_i),
		.sys_rst_i  (sys_rst_i),
		.advance_i  (advance),
		.pix_stb_i  (pix_stb_i),
		.pix_i      (pix_i),
		.lane_ops_o (lane_ops),
		.dadr_o     (feed_dadr)
	);

	// One lane per colour channel, index 0 is red
	for (genvar i = 0; i < pixfx_pkg::LANE_COUNT; i++) begin : g_lane
		pixfx_lane i_lane (
			.sys_clk_i (sys_clk_i),
			.sys_rst_i (sys_rst_i),
			.advance_i (advance),
			.cfg_i     (cfg_i),
			.ops_i     (lane_ops[i]),
			.res_o     (lane_res[i])
		);
	end

	pixfx_pack i_pack (
		.sys_clk_i  (sys_clk_i),
		.sys_rst_i  (sys_rst_i),
		.cfg_i      (cfg_i),
		.pix_stb_i  (pix_stb_i),
		.dadr_i     (feed_dadr),
		.lane_res_i (lane_res),
		.pix_ack_i  (pix_ack_i),
		.advance_o  (advance),
		.pix_ack_o  (pix_ack_o),
		.pix_stb_o  (pix_stb_o),
		.pix_o      (pix_o),
		.busy_o     (busy_o)
	);

endmodule

// File: dv/pixfx_assertions.sv
// ====================
// Handshake and reset checks bound to pixfx_top
// ====================

`timescale 1ns/1ps

module pixfx_assertions (
	input logic                sys_clk_i,
	input logic                sys_rst_i,
	input logic                in_ack_i,   // DUT pix_ack_o
	input logic                out_stb_i,  // DUT pix_stb_o
	input logic                out_ack_i,  // DUT pix_ack_i
	input pixfx_pkg::pix_out_t out_pix_i,
	input logic                busy_i
);

	// ====================
	// Reset
	// ====================
	// Outputs settle after the first reset edge and stay quiet
	property p_quiet_in_reset;
		@(posedge sys_clk_i) sys_rst_i && $past(sys_rst_i)
			|-> !out_stb_i && !in_ack_i && !busy_i;
	endproperty
	a_quiet_in_reset: assert property (p_quiet_in_reset)
		else $error("Output strobe, input ack or busy high during reset");

	// ====================
	// Handshake
	// ====================
	property p_hold_when_stalled;
		@(posedge sys_clk_i) disable iff (sys_rst_i)
			out_stb_i && !out_ack_i |=> out_stb_i && $stable(out_pix_i);
	endproperty
	a_hold_when_stalled: assert property (p_hold_when_stalled)
		else $error("Output pixel changed or vanished while stalled");

	// Empty output register means the input side is open
	property p_ack_when_empty;
		@(posedge sys_clk_i) disable iff (sys_rst_i)
			!out_stb_i && !$past(sys_rst_i) |-> in_ack_i;
	endproperty
	a_ack_when_empty: assert property (p_ack_when_empty)
		else $error("Input not acknowledged with an empty output register");

endmodule

// File: dv/pixfx_tb.sv
// ====================
// Testbench for pixfx_top, random pixels and random output back-pressure
// Expected colours follow the blend, decay, alpha and key rules in integer math
// Config changes only between batches, with the engine idle
// ====================

`timescale 1ns/1ps

module pixfx_tb;

	localparam int          CLK_PERIOD    = 20;
	localparam int          RESET_CYCLES  = 8;
	localparam int          NUM_BATCHES   = 6;
	localparam int          PIX_PER_BATCH = 150;
	localparam int          STALL_ALLOW   = 10;  // Cycles per pixel at heaviest back-pressure
	localparam int          WATCHDOG_NS   =
		(NUM_BATCHES * PIX_PER_BATCH * STALL_ALLOW + 200) * CLK_PERIOD;
	localparam logic [31:0] SEED          = 32'he97d_cee2;

	logic                sys_clk;
	logic                sys_rst;
	pixfx_pkg::cfg_t     cfg;
	logic                in_stb;
	pixfx_pkg::pix_in_t  in_pix;
	logic                in_ack;
	logic                out_stb;
	pixfx_pkg::pix_out_t out_pix;
	logic                out_ack;
	logic                busy;

	pixfx_pkg::pix_out_t exp_q [$];  // Scoreboard, oldest first
	int                  keyed_cnt;

	pixfx_top i_dut (
		.sys_clk_i (sys_clk),
		.sys_rst_i (sys_rst),
		.cfg_i     (cfg),
		.pix_stb_i (in_stb),
		.pix_i     (in_pix),
		.pix_ack_o (in_ack),
		.pix_stb_o (out_stb),
		.pix_o     (out_pix),
		.pix_ack_i (out_ack),
		.busy_o    (busy)
	);

	bind pixfx_top pixfx_assertions i_assertions (
		.sys_clk_i (sys_clk_i),
		.sys_rst_i (sys_rst_i),
		.in_ack_i  (pix_ack_o),
		.out_stb_i (pix_stb_o),
		.out_ack_i (pix_ack_i),
		.out_pix_i (pix_o),
		.busy_i    (busy_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// ====================
	// Reporting
	// ====================
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("Mismatch %s: actual 0x%h, expected 0x%h",
				name, actual, expected));
		end
	endtask

	// ====================
	// Reference model
	// ====================
	// Channel widened to 6 bits, red and blue doubled
	function automatic int chan_value(input pixfx_pkg::rgb565_t c, input int ch);
		case (ch)
			0:       return int'(c[15:11]) * 2;
			1:       return int'(c[10:5]);
			default: return int'(c[4:0]) * 2;
		endcase
	endfunction

	function automatic pixfx_pkg::rgb565_t pack565(input int r, input int g, input int b);
		return 16'((r / 2) * 2048 + g * 32 + b / 2);
	endfunction

	task automatic model_accept(input pixfx_pkg::pix_in_t p);
		int                  xf;
		int                  yf;
		int                  alpha;
		int                  ch;
		int                  decay;
		int                  bl [3];
		int                  fin [3];
		pixfx_pkg::pix_out_t want;
		xf    = int'(p.x_frac);
		yf    = int'(p.y_frac);
		alpha = int'(cfg.alpha);
		for (ch = 0; ch < pixfx_pkg::LANE_COUNT; ch++) begin
			bl[ch] = (chan_value(p.colora, ch) * (64 - xf) * (64 - yf)
				+ chan_value(p.colorb, ch) * xf * (64 - yf)
				+ chan_value(p.colorc, ch) * (64 - xf) * yf
				+ chan_value(p.colord, ch) * xf * yf) / 4096;
			decay = bl[ch] * (int'(cfg.brightness) + 1) / 64;
			if (cfg.alpha_en) begin
				fin[ch] = (decay * (alpha + 1) + chan_value(p.dcolor, ch) * (63 - alpha)) / 64;
			end else begin
				fin[ch] = decay;
			end
		end
		if (cfg.chroma_key_en && pack565(bl[0], bl[1], bl[2]) == cfg.chroma_key) begin
			keyed_cnt++;  // Dropped, never leaves the DUT
		end else begin
			want.dadr  = p.dadr;
			want.color = pack565(fin[0], fin[1], fin[2]);
			exp_q.push_back(want);
		end
	endtask

	// ====================
	// Stimulus
	// ====================
	task automatic next_cycle(input int stall_pct);
		@(posedge sys_clk);
		#2;
		out_ack = ($urandom_range(99) >= stall_pct);
	endtask

	function automatic pixfx_pkg::pix_in_t random_pixel(input int key_pct);
		pixfx_pkg::pix_in_t p;
		p.colora = 16'($urandom);
		p.colorb = 16'($urandom);
		p.colorc = 16'($urandom);
		p.colord = 16'($urandom);
		p.dcolor = 16'($urandom);
		p.x_frac = 6'($urandom);
		p.y_frac = 6'($urandom);
		p.dadr   = 24'($urandom);
		if ($urandom_range(99) < key_pct) begin
			p.colora = cfg.chroma_key;  // Flat patch in the key colour
			p.colorb = cfg.chroma_key;
			p.colorc = cfg.chroma_key;
			p.colord = cfg.chroma_key;
		end
		return p;
	endfunction

	task automatic set_config(input int bright, input logic alpha_en, input logic key_en);
		@(posedge sys_clk);
		#2;
		cfg.brightness    = 6'(bright);
		cfg.alpha_en      = alpha_en;
		cfg.alpha         = 6'($urandom_range(63));
		cfg.chroma_key_en = key_en;
		cfg.chroma_key    = 16'($urandom);
		keyed_cnt         = 0;
	endtask

	task automatic run_batch(input int stall_pct, input int key_pct);
		int   sent;
		logic took;
		sent = 0;
		took = 1'b0;
		while (sent < PIX_PER_BATCH) begin
			next_cycle(stall_pct);
			if (!in_stb || took) begin  // Hold the pixel until it is taken
				in_stb = ($urandom_range(99) < 80);
				in_pix = random_pixel(key_pct);
			end
			@(negedge sys_clk);
			took = in_stb && in_ack;
			if (took) begin
				model_accept(in_pix);
				sent++;
			end
		end
		next_cycle(stall_pct);
		in_stb = 1'b0;
		@(negedge sys_clk);
		while (busy) begin
			next_cycle(stall_pct);
			@(negedge sys_clk);
		end
		if (exp_q.size() != 0) begin
			abort_run($sformatf("%0d expected pixels missing after the engine went idle",
				exp_q.size()));
		end
		$display("Batch done: %0d pixels, %0d keyed, stall %0d%%", sent, keyed_cnt, stall_pct);
	endtask

	// Output side, sampled mid-cycle where everything is stable
	always @(negedge sys_clk) begin
		pixfx_pkg::pix_out_t want;
		if (!sys_rst && out_stb && out_ack) begin
			if (exp_q.size() == 0) begin
				abort_run("Output pixel appeared while no pixel was expected");
			end else begin
				want = exp_q.pop_front();
				check_value("pix_o.dadr", 32'(out_pix.dadr), 32'(want.dadr));
				check_value("pix_o.color", 32'(out_pix.color), 32'(want.color));
			end
		end
	end

	// ====================
	// Main sequence
	// ====================
	initial begin
		void'($urandom(SEED));
		sys_rst   = 1'b1;
		in_stb    = 1'b0;
		in_pix    = '0;
		out_ack   = 1'b0;
		cfg       = '0;
		keyed_cnt = 0;
		repeat (RESET_CYCLES - 1) @(posedge sys_clk);
		@(negedge sys_clk);
		check_value("pix_ack_o", 32'(in_ack), 32'h0);
		check_value("pix_stb_o", 32'(out_stb), 32'h0);
		@(posedge sys_clk);
		#2;
		sys_rst = 1'b0;
		@(negedge sys_clk);
		check_value("pix_stb_o", 32'(out_stb), 32'h0);
		check_value("busy_o", 32'(busy), 32'h0);
		@(negedge sys_clk);
		check_value("pix_ack_o", 32'(in_ack), 32'h1);  // Input opens one cycle after reset

		set_config(63, 1'b0, 1'b0);  // Plain bilinear blend
		run_batch(0, 0);
		set_config($urandom_range(63), 1'b0, 1'b0);
		run_batch(0, 0);
		set_config($urandom_range(63), 1'b1, 1'b0);
		run_batch(0, 0);
		set_config($urandom_range(63), 1'b1, 1'b1);
		run_batch(0, 30);
		if (keyed_cnt == 0) begin
			abort_run("Chroma key batch produced no keyed pixel");
		end
		set_config($urandom_range(63), 1'($urandom), 1'b1);
		run_batch(40, 20);
		set_config($urandom_range(63), 1'b1, 1'b0);  // Heavy back-pressure
		run_batch(70, 0);

		if (exp_q.size() == 0 && !busy) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			abort_run("Engine not idle or pixels still expected at the end");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run($sformatf("Timeout: run did not finish within %0d ns", WATCHDOG_NS));
	end

endmodule

// File: tb.f
src/pixfx_pkg.sv
src/pixfx_unpack.sv
src/pixfx_lane.sv
src/pixfx_pack.sv
src/pixfx_top.sv
dv/pixfx_assertions.sv
dv/pixfx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the pixfx testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module pixfx_tb -Mdir obj_dir \
	|| { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vpixfx_tb 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qxF "TEST RESULT: PASS" \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }
